// File: Makefile
# Verilator build and run for the stream switch testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= stream_switch_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result; a missing pass line also counts as failure
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
logic/stream_pkg.sv
logic/timing_pkg.sv
logic/stream_activity.sv
logic/dwell_timer.sv
logic/stream_scanner.sv
logic/stream_mux.sv
logic/stream_switch_top.sv
sim/stream_switch_checker.sv
sim/stream_switch_tb.sv

// File: logic/dwell_timer.sv
`timescale 1ns/1ps

module dwell_timer
	import timing_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  logic bt_state,
	input  logic timer_restart,
	output logic timer_done
);

	logic [dwell_width-1:0] count;
	logic at_cap;

	assign at_cap = (count == dwell_cap);

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count <= '0;
		end
		else if (!bt_state)
		begin
			count <= '0; // a dropped link throws away the dwell
		end
		else if (timer_restart)
		begin
			count <= '0;
		end
		else if (!at_cap)
		begin
			count <= count + 1'b1;
		end
		// at the cap the count waits for the scanner to restart it
	end

	assign timer_done = bt_state && at_cap;

	assert property (@(posedge clock) disable iff (!arst_n)
		count <= dwell_cap);

endmodule

// File: logic/stream_activity.sv
`timescale 1ns/1ps

module stream_activity
	import stream_pkg::*;
	import timing_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  logic [stream_count-1:0] stream_strobe,
	output logic [stream_count-1:0] open_streams
);

	// one down counter per stream, reloaded by its strobe
	logic [activity_width-1:0] remaining [stream_count];

	genvar s;
	generate
		for (s = 0; s < stream_count; s++)
		begin : g_lane

			always_ff @(posedge clock or negedge arst_n)
			begin
				if (!arst_n)
				begin
					remaining[s] <= '0;
				end
				else if (stream_strobe[s])
				begin
					remaining[s] <= activity_load; // a fresh sample restarts the window
				end
				else if (remaining[s] != '0)
				begin
					remaining[s] <= remaining[s] - 1'b1;
				end
			end

			// the lane stays open while any of the window is left
			assign open_streams[s] = (remaining[s] != '0);

		end
	endgenerate

endmodule

// File: logic/stream_mux.sv
`timescale 1ns/1ps

module stream_mux
	import stream_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  sel_word_u next_sel,
	input  logic [stream_count-1:0] stream_strobe,
	input  logic [stream_count*sample_width-1:0] stream_data,
	output logic [sample_width-1:0] out_data,
	output logic out_strobe,
	output logic out_idle,
	output logic [index_width-1:0] out_index
);

	logic [sample_width-1:0] lane_data;
	logic lane_strobe;

	// pick the lane named by the index part of the selection
	assign lane_data = stream_data[next_sel.fields.index*sample_width +: sample_width];
	assign lane_strobe = stream_strobe[next_sel.fields.index];

	always_ff @(posedge clock)
	begin
		out_data <= lane_data;
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_strobe <= 1'b0;
			out_idle <= 1'b1;
			out_index <= '0;
		end
		else
		begin
			out_strobe <= lane_strobe && !next_sel.fields.idle; // nothing leaves while idle
			out_idle <= next_sel.fields.idle;
			out_index <= next_sel.fields.index;
		end
	end

endmodule

// File: logic/stream_pkg.sv
package stream_pkg;

	// eight audio streams come in over the bt link
	localparam int stream_count = 8;
	localparam int sample_width = 16;
	localparam int index_width = $clog2(stream_count);

	// the selection word names one stream or none
	typedef struct packed
	{
		logic idle; // set when no stream is selected
		logic [index_width-1:0] index;
	} sel_fields_s;

	typedef union packed
	{
		logic [index_width:0] raw;
		sel_fields_s fields;
	} sel_word_u;

	localparam logic [index_width:0] sel_idle = 4'b1000; // idle flag set, index left at zero

	// selection a stream index gives when read as a raw code
	function automatic logic [index_width:0] sel_of(input logic [index_width-1:0] index);
		sel_word_u word;
		word.fields.idle = 1'b0;
		word.fields.index = index;
		return word.raw;
	endfunction

endpackage

// File: logic/stream_scanner.sv
`timescale 1ns/1ps

module stream_scanner
	import stream_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  logic bt_state,
	input  logic timer_done,
	input  logic [stream_count-1:0] open_streams,
	output logic timer_restart,
	output sel_word_u next_sel
);

	// candidate pointer and the run of closed candidates seen so far
	logic [index_width-1:0] ptr;
	logic [index_width-1:0] misses;
	logic hit;
	logic full_miss;

	assign hit = open_streams[ptr];
	assign full_miss = (misses == index_width'(stream_count - 1));

	// pulse in the cycle the choice is made, so the timer clears with it
	assign timer_restart = timer_done && hit;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ptr <= '0;
			misses <= '0;
			next_sel.raw <= sel_idle;
		end
		else if (!bt_state)
		begin
			ptr <= '0; // the first pick after the link returns starts at stream 0
			misses <= '0;
			next_sel.raw <= sel_idle;
		end
		else if (timer_done)
		begin
			ptr <= ptr + 1'b1; // wraps from the last stream to stream 0
			if (hit)
			begin
				next_sel.raw <= sel_of(ptr);
				misses <= '0;
			end
			else
			begin
				misses <= misses + 1'b1;
				if (full_miss)
				begin
					next_sel.raw <= sel_idle; // a full turn found nothing open
				end
			end
		end
	end

	// the scanner may only move on after the dwell has run out
	assert property (@(posedge clock) disable iff (!arst_n)
		timer_restart |-> timer_done);

	// whatever gets picked was open on the cycle it was picked
	assert property (@(posedge clock) disable iff (!arst_n)
		$past(timer_restart) |->
			!next_sel.fields.idle
			&& ((($past(open_streams) >> next_sel.fields.index) & 8'd1) == 8'd1));

endmodule

// File: logic/stream_switch_top.sv
`timescale 1ns/1ps

module stream_switch_top
(
	input  logic clock,
	input  logic arst_n,
	input  logic bt_state,
	input  logic [7:0] stream_strobe,
	input  logic [127:0] stream_data,
	output logic [15:0] out_data,
	output logic out_strobe,
	output logic [2:0] out_index,
	output logic out_idle
);

	logic [7:0] open_streams;
	logic timer_done;
	logic timer_restart;
	stream_pkg::sel_word_u next_sel;

	stream_activity activity_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.stream_strobe (stream_strobe),
		.open_streams  (open_streams)
	);

	dwell_timer timer_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.bt_state      (bt_state),
		.timer_restart (timer_restart),
		.timer_done    (timer_done)
	);

	stream_scanner scanner_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.bt_state      (bt_state),
		.timer_done    (timer_done),
		.open_streams  (open_streams),
		.timer_restart (timer_restart),
		.next_sel      (next_sel)
	);

	// the selection is registered once more here on the way out
	stream_mux mux_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.next_sel      (next_sel),
		.stream_strobe (stream_strobe),
		.stream_data   (stream_data),
		.out_data      (out_data),
		.out_strobe    (out_strobe),
		.out_idle      (out_idle),
		.out_index     (out_index)
	);

endmodule

// File: logic/timing_pkg.sv
package timing_pkg;

	// dwell of roughly 800 ms at the slow system clock
	localparam int dwell_cycles = 385;

	// one extra bit above what the cap needs
	localparam int dwell_width = $clog2(dwell_cycles) + 1;

	// cycles a stream counts as open after its last strobe
	localparam int activity_window = 64;

	// wide enough to hold the full window value
	localparam int activity_width = $clog2(activity_window) + 1;

	localparam logic [dwell_width-1:0] dwell_cap = dwell_width'(dwell_cycles);
	localparam logic [activity_width-1:0] activity_load = activity_width'(activity_window);

endpackage

// File: sim/stream_switch_checker.sv
`timescale 1ns/1ps

module stream_switch_checker
	import stream_pkg::*;
	import timing_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  logic bt_state,
	input  logic [7:0] stream_strobe,
	input  logic [127:0] stream_data,
	input  logic [15:0] out_data,
	input  logic out_strobe,
	input  logic [2:0] out_index,
	input  logic out_idle,
	input  int row_id,
	input  logic exp_idle,
	input  logic [2:0] exp_index,
	output int pass_count,
	output int fail_count
);

	// reference state rebuilt from the port activity alone
	int window_left [stream_count];
	int dwell_count;
	logic [2:0] cand;
	int closed_run; // closed candidates seen since the last pick
	logic sel_none;
	logic [2:0] sel_idx;
	logic want_strobe;
	logic want_idle;
	logic [2:0] want_index;
	logic [15:0] want_data;

	int cur_row;
	int row_errors;
	logic row_exp_idle;
	logic [2:0] row_exp_index;
	string visits;
	logic seen_idle;
	logic [2:0] seen_index;
	int held;

	initial
	begin
		pass_count = 0;
		fail_count = 0;
		cur_row = -1;
		row_errors = 0;
		visits = "";
	end

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
		if (got !== want)
		begin
			$display("FAIL %s: got %h expected %h", name, got, want);
			fail_count++;
			row_errors++;
		end
		else
		begin
			pass_count++;
		end
	endtask

	task automatic close_row();
		compare("out_idle", 16'(out_idle), 16'(row_exp_idle));
		if (!row_exp_idle)
		begin
			compare("out_index", 16'(out_index), 16'(row_exp_index));
		end
		if (visits.len() == 0)
		begin
			visits = " none";
		end
		$display("row %0d finished with %0d errors, visits:%s", cur_row, row_errors, visits);
	endtask

	task automatic track_selection();
		if (out_idle != seen_idle || out_index != seen_index)
		begin
			if (!out_idle && !seen_idle && held < dwell_cycles)
			begin
				$display("stream %0d was selected for only %0d cycles before the next one",
					seen_index, held);
				fail_count++;
				row_errors++;
			end
			if (!out_idle)
			begin
				visits = {visits, $sformatf(" %0d", out_index)};
			end
			seen_idle = out_idle;
			seen_index = out_index;
			held = 1;
		end
		else
		begin
			held++;
		end
	endtask

	task automatic advance_model();
		logic expired;
		logic lit;
		expired = bt_state && (dwell_count == dwell_cycles);
		lit = (window_left[cand] != 0);
		// the output stage shows the selection that stood before this edge
		want_idle = sel_none;
		want_index = sel_idx;
		want_strobe = !sel_none && stream_strobe[sel_idx];
		want_data = stream_data[sel_idx*16 +: 16];
		if (!bt_state)
		begin
			dwell_count = 0;
			cand = '0;
			closed_run = 0;
			sel_none = 1'b1;
			sel_idx = '0;
		end
		else
		begin
			if (expired && lit)
				dwell_count = 0;
			else if (dwell_count < dwell_cycles)
				dwell_count++;
			if (expired)
			begin
				if (lit)
				begin
					sel_none = 1'b0;
					sel_idx = cand;
					closed_run = 0;
				end
				else
				begin
					closed_run++;
					if (closed_run == stream_count)
					begin
						sel_none = 1'b1; // a whole turn without an open stream
						sel_idx = '0;
						closed_run = 0;
					end
				end
				cand = cand + 1'b1;
			end
		end
		for (int s = 0; s < stream_count; s++)
		begin
			if (stream_strobe[s])
				window_left[s] = activity_window;
			else if (window_left[s] > 0)
				window_left[s]--;
		end
	endtask

	always @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < stream_count; s++)
				window_left[s] = 0;
			dwell_count = 0;
			cand = '0;
			closed_run = 0;
			sel_none = 1'b1;
			sel_idx = '0;
			want_strobe = 1'b0;
			want_idle = 1'b1;
			want_index = '0;
			want_data = '0;
			seen_idle = 1'b1;
			seen_index = '0;
			held = 0;
		end
		else
		begin
			if (row_id != cur_row)
			begin
				if (cur_row >= 0)
					close_row();
				cur_row = row_id;
				row_exp_idle = exp_idle;
				row_exp_index = exp_index;
				row_errors = 0;
				visits = "";
			end
			compare("out_strobe", 16'(out_strobe), 16'(want_strobe));
			compare("out_idle", 16'(out_idle), 16'(want_idle));
			compare("out_index", 16'(out_index), 16'(want_index));
			if (want_strobe)
				compare("out_data", out_data, want_data);
			track_selection();
			advance_model();
		end
	end

endmodule

// File: sim/stream_switch_tb.sv
`timescale 1ns/1ps

module stream_switch_tb;

	typedef struct packed
	{
		logic bt;
		logic [7:0] mask; // streams that strobe during the row
		logic [15:0] cycles;
		logic exp_idle;
		logic [2:0] exp_index;
	} scenario_s;

	localparam int row_count = 8;
	localparam int reset_cycles = 5;

	// expected values are the selection left standing when the row ends
	localparam scenario_s scenarios [row_count] = '{
		'{bt: 1'b0, mask: 8'hff, cycles: 16'd100, exp_idle: 1'b1, exp_index: 3'd0},
		'{bt: 1'b1, mask: 8'h52, cycles: 16'd1700, exp_idle: 1'b0, exp_index: 3'd1}, // 1, 4, 6, 1
		'{bt: 1'b1, mask: 8'h50, cycles: 16'd1100, exp_idle: 1'b0, exp_index: 3'd4}, // stream 1 falls silent
		'{bt: 1'b1, mask: 8'h00, cycles: 16'd600, exp_idle: 1'b1, exp_index: 3'd0},
		'{bt: 1'b1, mask: 8'h08, cycles: 16'd200, exp_idle: 1'b0, exp_index: 3'd3},
		'{bt: 1'b0, mask: 8'h08, cycles: 16'd20, exp_idle: 1'b1, exp_index: 3'd0}, // drop mid dwell
		'{bt: 1'b1, mask: 8'h22, cycles: 16'd500, exp_idle: 1'b0, exp_index: 3'd1}, // scan restarts at 0
		'{bt: 1'b0, mask: 8'hff, cycles: 16'd50, exp_idle: 1'b1, exp_index: 3'd0}
	};

	logic clock;
	logic arst_n;
	logic bt_state;
	logic [7:0] stream_strobe;
	logic [127:0] stream_data;
	logic [15:0] out_data;
	logic out_strobe;
	logic [2:0] out_index;
	logic out_idle;

	int row_id;
	logic exp_idle;
	logic [2:0] exp_index;
	int pass_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;

	stream_switch_top dut_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.bt_state      (bt_state),
		.stream_strobe (stream_strobe),
		.stream_data   (stream_data),
		.out_data      (out_data),
		.out_strobe    (out_strobe),
		.out_index     (out_index),
		.out_idle      (out_idle)
	);

	stream_switch_checker check_i (
		.clock         (clock),
		.arst_n        (arst_n),
		.bt_state      (bt_state),
		.stream_strobe (stream_strobe),
		.stream_data   (stream_data),
		.out_data      (out_data),
		.out_strobe    (out_strobe),
		.out_index     (out_index),
		.out_idle      (out_idle),
		.row_id        (row_id),
		.exp_idle      (exp_idle),
		.exp_index     (exp_index),
		.pass_count    (pass_count),
		.fail_count    (fail_count)
	);

	always #50 clock = ~clock;

	function automatic int table_cycles();
		int total;
		total = 0;
		for (int r = 0; r < row_count; r++)
			total += int'(scenarios[r].cycles);
		return total;
	endfunction

	task automatic drive_cycle(input scenario_s row, input int step);
		logic [127:0] samples;
		logic [2:0] slot;
		@(negedge clock);
		for (int s = 0; s < 8; s++)
			samples[s*16 +: 16] = 16'($urandom);
		slot = 3'(step); // each stream owns one slot out of eight
		bt_state = row.bt;
		stream_data = samples;
		stream_strobe = '0;
		stream_strobe[slot] = row.mask[slot];
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("the run timed out after %0d cycles before the table was done", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'h42c1));
		clock = 1'b0;
		arst_n = 1'b0;
		bt_state = 1'b0;
		stream_strobe = '0;
		stream_data = '0;
		row_id = -1;
		exp_idle = 1'b1;
		exp_index = '0;
		cycle_count = 0;
		cycle_limit = table_cycles() + reset_cycles + 1000;

		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		for (int r = 0; r < row_count; r++)
		begin
			for (int step = 0; step < int'(scenarios[r].cycles); step++)
			begin
				drive_cycle(scenarios[r], step);
				if (step == 0)
				begin
					row_id = r;
					exp_idle = scenarios[r].exp_idle;
					exp_index = scenarios[r].exp_index;
				end
			end
		end

		@(negedge clock);
		row_id = row_count; // lets the checker close the last row
		@(negedge clock);
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
